/* Makefile */
# Verilator build and run of the multiply/divide unit testbench

TOP := tb_int_muldiv_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

# passes only when the pass message shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

/* files.f */
muldiv_pkg.sv
int_mul_dpath.sv
int_mul_ctrl.sv
int_mul_iterative.sv
int_div_iterative.sv
int_muldiv_unit.sv
tb_int_muldiv_unit.sv

/* int_div_iterative.sv */
/*
  Restoring divider, one quotient bit per cycle, signed or unsigned.
  Result is {remainder, quotient}. Divide by zero gives quotient all ones, remainder a.
*/
`timescale 1ns/1ps
`default_nettype none

module int_div_iterative (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       req_val,
  output logic                      req_rdy,
  input  wire muldiv_pkg::operand_t a,
  input  wire muldiv_pkg::operand_t b,
  input  wire                       is_signed,
  output logic                      resp_val,
  input  wire                       resp_rdy,
  output muldiv_pkg::result_t       result
);
  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    div_idle,
    div_calc,
    div_done
  } div_state_t;

  div_state_t state;
  div_state_t state_next;
  iter_cnt_t  counter;

  // quotient register starts out holding the dividend
  operand_t quo_reg;
  operand_t rem_reg;
  operand_t divisor_reg;

  // latched sign info
  logic quo_neg;
  logic rem_neg;
  logic div_by_zero;

  logic     a_neg;
  logic     b_neg;
  operand_t a_mag;
  operand_t b_mag;

  logic req_go;

  // one restoring step
  logic [xlen:0]   rem_shift;
  logic [xlen+1:0] rem_diff;
  logic            fits;

  operand_t quo_out;
  operand_t rem_out;

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  assign req_rdy  = (state == div_idle);
  assign resp_val = (state == div_done);
  assign req_go   = req_rdy & req_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= div_idle;
      counter <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        counter <= last_iter;
      end else if (state == div_calc) begin
        counter <= counter - 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      div_idle: if (req_val) state_next = div_calc;
      // 32nd step happens on the edge that leaves calc
      div_calc: if (counter == '0) state_next = div_done;
      div_done: if (resp_rdy) state_next = div_idle;
      default:  state_next = div_idle;
    endcase
  end

  // --------------------------------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------------------------------

  // unsigned requests pass the raw operands
  assign a_neg = is_signed & a[xlen-1];
  assign b_neg = is_signed & b[xlen-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // --------------------------------------------------------------------------
  // restoring step
  // --------------------------------------------------------------------------

  // remainder can briefly need 33 bits after the shift
  assign rem_shift = {rem_reg, quo_reg[xlen-1]};
  assign rem_diff  = {1'b0, rem_shift} - {2'b00, divisor_reg};
  // no borrow means the divisor fits
  assign fits      = ~rem_diff[xlen+1];

  always_ff @(posedge clk) begin
    if (req_go) begin
      quo_reg     <= a_mag;
      rem_reg     <= '0;
      divisor_reg <= b_mag;
      quo_neg     <= a_neg ^ b_neg;
      rem_neg     <= a_neg;
      div_by_zero <= (b == '0);
    end else if (state == div_calc) begin
      // remainder stays below the divisor, so 32 bits hold it
      rem_reg <= fits ? rem_diff[xlen-1:0] : rem_shift[xlen-1:0];
      quo_reg <= {quo_reg[xlen-2:0], fits};
    end
  end

  // --------------------------------------------------------------------------
  // output sign fix
  // --------------------------------------------------------------------------

  // zero divisor: every step fits, so the remainder ends as |a|
  // and the dividend sign turns it back into a
  assign quo_out = div_by_zero ? '1 : (quo_neg ? (~quo_reg + 1'b1) : quo_reg);
  assign rem_out = rem_neg ? (~rem_reg + 1'b1) : rem_reg;

  assign result = {rem_out, quo_out};

endmodule

`default_nettype wire

/* int_mul_ctrl.sv */
/*
  Multiplier controller: idle, calc and done.
  Calc runs until the datapath counter reaches zero. Done holds until resp_rdy.
*/
`timescale 1ns/1ps
`default_nettype none

module int_mul_ctrl (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   req_val,
  output logic                  req_rdy,
  output logic                  resp_val,
  input  wire                   resp_rdy,
  input  wire                   counter_is_zero,
  output muldiv_pkg::mul_ctrl_t ctrl
);

  typedef enum logic [1:0] {
    mul_idle,
    mul_calc,
    mul_done
  } mul_state_t;

  mul_state_t state;
  mul_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mul_idle;
    end else begin
      state <= state_next;
    end
  end

  // next state
  always_comb begin
    state_next = state;
    case (state)
      mul_idle: if (req_val) state_next = mul_calc;
      // leave after the step taken on the last count
      mul_calc: if (counter_is_zero) state_next = mul_done;
      mul_done: if (resp_rdy) state_next = mul_idle;
      default:  state_next = mul_idle;
    endcase
  end

  // handshake outputs follow the state directly
  assign req_rdy  = (state == mul_idle);
  assign resp_val = (state == mul_done);

  // load only on the accepting edge, step on every calc cycle
  assign ctrl.load = req_rdy & req_val;
  assign ctrl.step = (state == mul_calc);

endmodule

`default_nettype wire

/* int_mul_dpath.sv */
/*
  Shift-add multiplier datapath, signed operands only.
  Works on magnitudes and fixes the product sign at the output.
*/
`timescale 1ns/1ps
`default_nettype none

module int_mul_dpath (
  input  wire                   clk,
  input  wire                   reset,
  input  wire muldiv_pkg::operand_t  a,
  input  wire muldiv_pkg::operand_t  b,
  input  wire muldiv_pkg::mul_ctrl_t ctrl,
  output logic                  counter_is_zero,
  output muldiv_pkg::result_t   result
);
  import muldiv_pkg::*;

  // stored operand signs
  logic      sign_a;
  logic      sign_b;

  // multiplicand, widened so it can shift left 31 times
  result_t   a_reg;
  // multiplier, consumed from the low end
  operand_t  b_reg;
  // partial product
  result_t   acc;
  // iterations left
  iter_cnt_t counter;

  operand_t  a_mag;
  operand_t  b_mag;

  // --------------------------------------------------------------------------
  // magnitude conversion
  // --------------------------------------------------------------------------

  // most negative value maps onto itself, which reads correctly as unsigned
  assign a_mag = a[xlen-1] ? (~a + 1'b1) : a;
  assign b_mag = b[xlen-1] ? (~b + 1'b1) : b;

  // --------------------------------------------------------------------------
  // shift-add registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      sign_a <= a[xlen-1];
      sign_b <= b[xlen-1];
      a_reg  <= {{xlen{1'b0}}, a_mag};
      b_reg  <= b_mag;
      acc    <= '0;
    end else if (ctrl.step) begin
      // add the shifted multiplicand when the current multiplier bit is set
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // iteration counter, the only one in the multiplier
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (ctrl.load) begin
      counter <= last_iter;
    end else if (ctrl.step) begin
      counter <= counter - 1'b1;
    end
  end

  assign counter_is_zero = (counter == '0);

  // --------------------------------------------------------------------------
  // output sign fix
  // --------------------------------------------------------------------------

  // negative only when exactly one operand was negative
  assign result = (sign_a ^ sign_b) ? (~acc + 1'b1) : acc;

endmodule

`default_nettype wire

/* int_mul_iterative.sv */
/*
  Iterative signed 32x32 multiplier, 64-bit product.
  One operation at a time, response 33 cycles after the request is taken.
*/
`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       req_val,
  output logic                      req_rdy,
  input  wire muldiv_pkg::operand_t a,
  input  wire muldiv_pkg::operand_t b,
  output logic                      resp_val,
  input  wire                       resp_rdy,
  output muldiv_pkg::result_t       result
);
  import muldiv_pkg::*;

  // control word and status between the two halves
  mul_ctrl_t ctrl_word;
  logic      counter_is_zero;

  // FSM deciding when to load and when to step
  int_mul_ctrl ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .ctrl            (ctrl_word)
  );

  // shift-add registers and sign handling
  int_mul_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .a               (a),
    .b               (b),
    .ctrl            (ctrl_word),
    .counter_is_zero (counter_is_zero),
    .result          (result)
  );

endmodule

`default_nettype wire

/* int_muldiv_unit.sv */
/*
  Multiply/divide unit top level. One operation in flight across both units,
  so responses come back in request order. Undefined func codes go to the divider.
*/
`timescale 1ns/1ps
`default_nettype none

module int_muldiv_unit (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          req_val,
  output logic                         req_rdy,
  input  wire muldiv_pkg::muldiv_req_t req_msg,
  output logic                         resp_val,
  input  wire                          resp_rdy,
  output muldiv_pkg::result_t          resp_msg
);
  import muldiv_pkg::*;

  // operation in flight, and which unit owns it (1 = divider)
  logic busy;
  logic owner_div;

  logic is_mul;
  logic is_signed;
  logic req_go;
  logic resp_go;

  // per-unit handshakes
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_result;

  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_result;

  // --------------------------------------------------------------------------
  // request steering
  // --------------------------------------------------------------------------

  assign is_mul    = (req_msg.func == func_mul);
  assign is_signed = (req_msg.func != func_divu);

  // both units sit idle whenever nothing is in flight
  assign req_rdy = ~busy & mul_req_rdy & div_req_rdy;
  assign req_go  = req_val & req_rdy;

  assign mul_req_val = req_val & ~busy & is_mul;
  assign div_req_val = req_val & ~busy & ~is_mul;

  // --------------------------------------------------------------------------
  // in-flight tracking
  // --------------------------------------------------------------------------

  assign resp_go = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_go) begin
      busy      <= 1'b1;
      owner_div <= ~is_mul;
    end else if (resp_go) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // units
  // --------------------------------------------------------------------------

  int_mul_iterative mul_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .a        (req_msg.a),
    .b        (req_msg.b),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .result   (mul_result)
  );

  int_div_iterative div_unit (
    .clk       (clk),
    .reset     (reset),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .a         (req_msg.a),
    .b         (req_msg.b),
    .is_signed (is_signed),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy),
    .result    (div_result)
  );

  // --------------------------------------------------------------------------
  // response mux
  // --------------------------------------------------------------------------

  // only the owner sees resp_rdy
  assign mul_resp_rdy = resp_rdy & ~owner_div;
  assign div_resp_rdy = resp_rdy & owner_div;

  assign resp_val = owner_div ? div_resp_val : mul_resp_val;
  assign resp_msg = owner_div ? div_result : mul_result;

endmodule

`default_nettype wire

/* muldiv_pkg.sv */
/*
  Shared types for the 32-bit iterative multiply/divide unit.
  Width and iteration count are fixed by the core and are not parameters.
*/
`default_nettype none

package muldiv_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // operand width of the core
  localparam int xlen = 32;

  // one iteration per operand bit
  localparam int num_iter = 32;

  // one source operand
  typedef logic [xlen-1:0] operand_t;

  // full response word
  // multiply gives the 64-bit product
  // divide packs {remainder, quotient}
  typedef logic [2*xlen-1:0] result_t;

  // down-counter over the iterations of one operation
  typedef logic [$clog2(num_iter)-1:0] iter_cnt_t;

  // counter value loaded at the start of an operation
  localparam iter_cnt_t last_iter = iter_cnt_t'(num_iter - 1);

  // --------------------------------------------------------------------------
  // request format
  // --------------------------------------------------------------------------

  // function codes
  // code 2'd3 is not defined and is steered to the divider by the top level
  typedef enum logic [1:0] {
    func_mul  = 2'd0,
    func_div  = 2'd1,
    func_divu = 2'd2
  } muldiv_func_t;

  // request message, 66 bits
  // func sits in the top bits, then a, then b
  typedef struct packed {
    muldiv_func_t func;
    operand_t     a;
    operand_t     b;
  } muldiv_req_t;

  // --------------------------------------------------------------------------
  // multiplier control word
  // --------------------------------------------------------------------------

  // load captures operands, clears the accumulator, sets the counter
  // step runs one shift-add iteration
  // the two are never high in the same cycle
  typedef struct packed {
    logic load;
    logic step;
  } mul_ctrl_t;

endpackage

`default_nettype wire

/* tb_int_muldiv_unit.sv */
/*
  Self-checking testbench for the multiply/divide unit, random seed 69.
  Expected results come from native 64-bit arithmetic, not from the DUT.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_int_muldiv_unit;
  import muldiv_pkg::*;

  localparam int clk_period   = 4;
  localparam int resp_latency = 33;
  localparam int max_stall    = 8;
  localparam int num_corner   = 5;
  localparam int num_random   = 40;
  localparam int total_ops    = 3 * num_corner * num_corner + 3 * num_random;
  // per operation: wait for accept, latency, worst stall, some slack
  localparam int watchdog_ns  = total_ops * (resp_latency + max_stall + 8) * clk_period + 2000;

  logic        clk = 1'b0;
  logic        reset;
  logic        req_val;
  logic        req_rdy;
  muldiv_req_t req_msg;
  logic        resp_val;
  logic        resp_rdy;
  result_t     resp_msg;

  int errors;
  int num_sent;
  int num_recv;
  int stall_left;

  // monitor state, one operation tracked at a time
  logic        in_flight;
  int          cycles;
  logic        hold_pending;
  logic        just_done;
  result_t     held_msg;
  result_t     expected;
  muldiv_req_t flight_req;

  int_muldiv_unit dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  // first edge is the rising one at half a period
  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reporting and reference model
  // --------------------------------------------------------------------------

  task automatic note_failure(input string what);
    errors++;
    $display("error: %s at %0t", what, $time);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
  endtask

  // divide results pack {remainder, quotient}
  function automatic result_t expected_result(input muldiv_req_t req);
    longint          sa;
    longint          sb;
    longint          quo;
    longint          rem;
    longint unsigned ua;
    longint unsigned ub;
    result_t         res;
    sa = longint'($signed(req.a));
    sb = longint'($signed(req.b));
    ua = {32'h0, req.a};
    ub = {32'h0, req.b};
    if (req.func == func_mul) begin
      res = result_t'(sa * sb);
    end else if (req.b == '0) begin
      // zero divisor: quotient all ones, remainder is the dividend
      res = {req.a, 32'hffff_ffff};
    end else begin
      if (req.func == func_divu) begin
        quo = longint'(ua / ub);
        rem = longint'(ua % ub);
      end else begin
        // truncating divide, remainder follows the dividend
        // min / -1 gives 2^31, whose low half is min again
        quo = sa / sb;
        rem = sa % sb;
      end
      res = {rem[31:0], quo[31:0]};
    end
    return res;
  endfunction

  function automatic operand_t corner_value(input int idx);
    case (idx)
      0: return 32'h0000_0000;
      1: return 32'h0000_0001;
      2: return 32'hffff_ffff;
      // most negative
      3: return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  // drive one request and hold it until the accepting edge
  task automatic send_op(input muldiv_func_t func, input operand_t a, input operand_t b);
    @(negedge clk);
    req_val      = 1'b1;
    req_msg.func = func;
    req_msg.a    = a;
    req_msg.b    = b;
    do begin
      @(posedge clk);
    end while (!req_rdy);
    num_sent++;
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // response back-pressure, random low stretches of resp_rdy
  // --------------------------------------------------------------------------

  initial begin
    resp_rdy   = 1'b0;
    stall_left = 0;
    forever begin
      @(negedge clk);
      if (stall_left > 0) begin
        resp_rdy   = 1'b0;
        stall_left = stall_left - 1;
      end else begin
        resp_rdy = 1'b1;
        if ($urandom % 3 == 0) begin
          stall_left = 1 + int'($urandom % max_stall);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // monitor, samples pre-edge values on every rising edge
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      in_flight    = 1'b0;
      cycles       = 0;
      hold_pending = 1'b0;
      just_done    = 1'b0;
    end else begin
      // first edge after a response handshake
      if (just_done) begin
        assert (req_rdy === 1'b1) else note_failure("req_rdy still low after the response");
      end
      just_done = 1'b0;
      if (in_flight) begin
        cycles = cycles + 1;
        assert (req_rdy === 1'b0) else note_failure("req_rdy high with an operation in flight");
        // low for 32 edges, then high until taken
        assert (resp_val === (cycles >= resp_latency))
          else report_mismatch("resp_val", 64'(resp_val), 64'(cycles >= resp_latency));
      end else begin
        assert (resp_val === 1'b0) else note_failure("resp_val high with nothing in flight");
      end
      // a stalled response must not move
      if (hold_pending) begin
        assert (resp_msg === held_msg) else report_mismatch("resp_msg", resp_msg, held_msg);
      end
      hold_pending = resp_val & ~resp_rdy;
      held_msg     = resp_msg;
      if (resp_val && resp_rdy) begin
        if (!in_flight) begin
          note_failure("response with no operation in flight");
        end else begin
          assert (resp_msg === expected) else begin
            report_mismatch("resp_msg", resp_msg, expected);
            $display("  func %0d a %h b %h", flight_req.func, flight_req.a, flight_req.b);
          end
        end
        in_flight = 1'b0;
        just_done = 1'b1;
        num_recv++;
      end
      if (req_val && req_rdy) begin
        in_flight  = 1'b1;
        cycles     = 0;
        flight_req = req_msg;
        expected   = expected_result(req_msg);
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin
    operand_t a_val;
    operand_t b_val;
    void'($urandom(69));
    reset    = 1'b1;
    req_val  = 1'b0;
    req_msg  = '0;
    errors   = 0;
    num_sent = 0;
    num_recv = 0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    assert (req_rdy === 1'b1) else note_failure("req_rdy low after reset");
    assert (resp_val === 1'b0) else note_failure("resp_val high after reset");

    // every corner pair for each function, zero divisors included
    for (int f = 0; f < 3; f++) begin
      for (int i = 0; i < num_corner; i++) begin
        for (int j = 0; j < num_corner; j++) begin
          send_op(muldiv_func_t'(f), corner_value(i), corner_value(j));
        end
      end
    end

    for (int n = 0; n < num_random; n++) begin
      a_val = $urandom;
      b_val = $urandom;
      send_op(func_mul, a_val, b_val);
      // small divisors give wide quotients, a few are zero
      if (n % 3 == 0) begin
        b_val = operand_t'($urandom % 16);
      end
      send_op(func_div, a_val, b_val);
      // top bit set on some unsigned operands
      if (n % 2 == 0) begin
        a_val = a_val | 32'h8000_0000;
      end
      if (n % 4 == 1) begin
        b_val = b_val | 32'h8000_0000;
      end
      send_op(func_divu, a_val, b_val);
    end

    wait (num_recv == num_sent);
    repeat (2) @(posedge clk);
    if (num_recv != num_sent) begin
      note_failure("response count differs from request count");
    end
    $display("errors: %0d, requests: %0d, responses: %0d", errors, num_sent, num_recv);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("timeout: run not done after %0d ns, errors: %0d, %0d of %0d responses seen",
             watchdog_ns, errors, num_recv, total_ops);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
